// ==== design/mips_pkg.sv ====
package mips_pkg;

	//////////////////////////////
	// Datapath widths
	//////////////////////////////

	localparam int data_width     = 32; // Register word and instruction width
	localparam int reg_count      = 32; // Architectural registers
	localparam int reg_addr_width = 5;  // Index into the register bank

	//////////////////////////////
	// Instruction field widths
	//////////////////////////////

	localparam int opcode_width = 6;  // Bits 31 to 26
	localparam int funct_width  = 6;  // Bits 5 to 0, R-format only
	localparam int imm_width    = 16; // Bits 15 to 0, I-format only

	//////////////////////////////
	// Opcodes
	//////////////////////////////

	// Register-register format, destination in rd
	localparam logic [opcode_width-1:0] op_rtype = 6'h00;

	// I-format opcodes with a destination in rt
	localparam logic [opcode_width-1:0] op_lw   = 6'h23; // Load word
	localparam logic [opcode_width-1:0] op_addi = 6'h08; // Add immediate
	localparam logic [opcode_width-1:0] op_ori  = 6'h0d; // Or immediate

	// I-format opcodes that leave the bank untouched
	localparam logic [opcode_width-1:0] op_sw  = 6'h2b; // Store word
	localparam logic [opcode_width-1:0] op_beq = 6'h04; // Branch on equal

endpackage

// ==== design/instr_decoder.sv ====
`timescale 1ns/100ps

module instr_decoder
(
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                instr_valid, // One-cycle strobe
	input  logic [mips_pkg::data_width-1:0]     instr,
	output logic [mips_pkg::reg_addr_width-1:0] rs_addr,     // Straight to the bank
	output logic [mips_pkg::reg_addr_width-1:0] rt_addr,     // Straight to the bank
	output logic                                dec_valid,
	output logic [mips_pkg::opcode_width-1:0]   opcode,
	output logic [mips_pkg::funct_width-1:0]    funct,
	output logic [mips_pkg::reg_addr_width-1:0] rs,
	output logic [mips_pkg::reg_addr_width-1:0] rt,
	output logic [mips_pkg::reg_addr_width-1:0] dest_reg,
	output logic                                reg_write,
	output logic [mips_pkg::data_width-1:0]     imm_ext
);

	logic [mips_pkg::opcode_width-1:0]   opcode_c; // Raw opcode field
	logic [mips_pkg::funct_width-1:0]    funct_c;  // Raw funct field
	logic [mips_pkg::reg_addr_width-1:0] rd_c;     // Raw rd field
	logic [mips_pkg::reg_addr_width-1:0] dest_c;   // Selected destination
	logic [mips_pkg::imm_width-1:0]      imm_c;    // Raw immediate
	logic                                writes_c; // Opcode writes a register

	//////////////////////////////
	// Field extraction
	//////////////////////////////

	assign opcode_c = instr[31:26];
	assign rs_addr  = instr[25:21]; // Bank reads this same cycle
	assign rt_addr  = instr[20:16];
	assign rd_c     = instr[15:11];
	assign funct_c  = instr[mips_pkg::funct_width-1:0];
	assign imm_c    = instr[mips_pkg::imm_width-1:0];

	always_comb
	begin
		case (opcode_c)
			mips_pkg::op_rtype,
			mips_pkg::op_lw,
			mips_pkg::op_addi,
			mips_pkg::op_ori:
				writes_c = 1'b1;
			default:
				writes_c = 1'b0; // sw, beq and anything unknown
		endcase
		// R-format names rd, every I-format names rt
		dest_c = (opcode_c == mips_pkg::op_rtype) ? rd_c : rt_addr;
	end

	//////////////////////////////
	// Decode register
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			dec_valid <= 1'b0;
			reg_write <= 1'b0;
		end
		else
		begin
			dec_valid <= instr_valid;
			reg_write <= instr_valid && writes_c && (dest_c != '0); // r0 never written
		end
	end

	always_ff @(posedge clk)
	begin
		if (instr_valid) // Payload only, held until next strobe
		begin
			opcode   <= opcode_c;
			funct    <= funct_c;
			rs       <= rs_addr;
			rt       <= rt_addr;
			dest_reg <= dest_c;
			imm_ext  <= {{(mips_pkg::data_width-mips_pkg::imm_width){imm_c[mips_pkg::imm_width-1]}},
				imm_c}; // Sign extend
		end
	end

	// Single-cycle strobes keep the decoded word to a one-cycle pulse
	a_dec_one_cycle: assert property (@(posedge clk) disable iff (reset)
		dec_valid |=> !dec_valid);

endmodule

// ==== design/wb_arbiter.sv ====
`timescale 1ns/100ps

module wb_arbiter
(
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                alu_wb_valid,  // ALU result strobe
	input  logic [mips_pkg::reg_addr_width-1:0] alu_wb_reg,
	input  logic [mips_pkg::data_width-1:0]     alu_wb_data,
	input  logic                                load_wb_valid, // Load result strobe
	input  logic [mips_pkg::reg_addr_width-1:0] load_wb_reg,
	input  logic [mips_pkg::data_width-1:0]     load_wb_data,
	output logic                                wr_en,         // Bank write port
	output logic [mips_pkg::reg_addr_width-1:0] wr_reg,
	output logic [mips_pkg::data_width-1:0]     wr_data
);

	logic                                slot_valid;  // Deferred ALU result present
	logic [mips_pkg::reg_addr_width-1:0] slot_reg;    // Deferred destination
	logic [mips_pkg::data_width-1:0]     slot_data;   // Deferred value
	logic                                alu_to_slot; // Fresh ALU result parked this cycle

	//////////////////////////////
	// Grant select
	//////////////////////////////

	// Priority is load, then slot, then fresh ALU
	always_comb
	begin
		wr_en       = 1'b0;
		wr_reg      = '0;
		wr_data     = '0;
		alu_to_slot = 1'b0;
		if (load_wb_valid)
		begin
			wr_en       = 1'b1;
			wr_reg      = load_wb_reg;
			wr_data     = load_wb_data;
			alu_to_slot = alu_wb_valid; // ALU loses the collision
		end
		else if (slot_valid)
		begin
			wr_en       = 1'b1;
			wr_reg      = slot_reg;
			wr_data     = slot_data;
			alu_to_slot = alu_wb_valid; // Refill keeps ALU order
		end
		else if (alu_wb_valid)
		begin
			wr_en   = 1'b1;
			wr_reg  = alu_wb_reg;
			wr_data = alu_wb_data;
		end
	end

	//////////////////////////////
	// Deferral slot
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
			slot_valid <= 1'b0;
		else if (alu_to_slot)
			slot_valid <= 1'b1;
		else if (!load_wb_valid)
			slot_valid <= 1'b0; // Drained, or never filled
	end

	always_ff @(posedge clk)
	begin
		if (alu_to_slot)
		begin
			slot_reg  <= alu_wb_reg;
			slot_data <= alu_wb_data;
		end
	end

	// Full slot plus a load leaves nowhere for a new ALU result
	a_no_slot_overflow: assert property (@(posedge clk) disable iff (reset)
		!(slot_valid && load_wb_valid && alu_wb_valid));

endmodule

// ==== design/register_bank.sv ====
`timescale 1ns/100ps

module register_bank
(
	input  logic                                clk,
	input  logic                                reset,
	input  logic [mips_pkg::reg_addr_width-1:0] rs_addr,     // First read port
	input  logic [mips_pkg::reg_addr_width-1:0] rt_addr,     // Second read port
	input  logic                                wr_en,       // From the arbiter
	input  logic [mips_pkg::reg_addr_width-1:0] wr_reg,
	input  logic [mips_pkg::data_width-1:0]     wr_data,
	output logic [mips_pkg::data_width-1:0]     read_data_1,
	output logic [mips_pkg::data_width-1:0]     read_data_2,
	output logic [mips_pkg::data_width-1:0]     jr_target    // Unregistered rs read
);

	logic [mips_pkg::data_width-1:0] regs [mips_pkg::reg_count]; // The register file

	//////////////////////////////
	// Write port
	//////////////////////////////

	// Falling edge so the next rising-edge read already sees it
	always_ff @(negedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < mips_pkg::reg_count; i++)
				regs[i] <= mips_pkg::data_width'(i); // Register i holds i
		end
		else if (wr_en && (wr_reg != '0))
			regs[wr_reg] <= wr_data; // r0 stays hardwired
	end

	//////////////////////////////
	// Read ports
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			read_data_1 <= '0;
			read_data_2 <= '0;
		end
		else
		begin
			read_data_1 <= regs[rs_addr];
			read_data_2 <= regs[rt_addr];
		end
	end

	assign jr_target = regs[rs_addr]; // Jump register path, no latency

	// r0 comes back zero whatever the arbiter sent it
	a_r0_port1: assert property (@(posedge clk) disable iff (reset)
		(rs_addr == '0) |=> (read_data_1 == '0));
	a_r0_port2: assert property (@(posedge clk) disable iff (reset)
		(rt_addr == '0) |=> (read_data_2 == '0));

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage
(
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                instr_valid,
	input  logic [mips_pkg::data_width-1:0]     instr,
	input  logic                                alu_wb_valid,
	input  logic [mips_pkg::reg_addr_width-1:0] alu_wb_reg,
	input  logic [mips_pkg::data_width-1:0]     alu_wb_data,
	input  logic                                load_wb_valid,
	input  logic [mips_pkg::reg_addr_width-1:0] load_wb_reg,
	input  logic [mips_pkg::data_width-1:0]     load_wb_data,
	output logic                                dec_valid,
	output logic [mips_pkg::opcode_width-1:0]   opcode,
	output logic [mips_pkg::funct_width-1:0]    funct,
	output logic [mips_pkg::reg_addr_width-1:0] rs,
	output logic [mips_pkg::reg_addr_width-1:0] rt,
	output logic [mips_pkg::reg_addr_width-1:0] dest_reg,
	output logic                                reg_write,
	output logic [mips_pkg::data_width-1:0]     imm_ext,
	output logic [mips_pkg::data_width-1:0]     read_data_1,
	output logic [mips_pkg::data_width-1:0]     read_data_2,
	output logic [mips_pkg::data_width-1:0]     jr_target
);

	logic [mips_pkg::reg_addr_width-1:0] rs_addr; // Decoder to bank, combinational
	logic [mips_pkg::reg_addr_width-1:0] rt_addr;
	logic                                wr_en;   // Arbiter to bank write port
	logic [mips_pkg::reg_addr_width-1:0] wr_reg;
	logic [mips_pkg::data_width-1:0]     wr_data;

	//////////////////////////////
	// Field decode
	//////////////////////////////

	instr_decoder u_instr_decoder
	(
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.rs_addr     (rs_addr),
		.rt_addr     (rt_addr),
		.dec_valid   (dec_valid),
		.opcode      (opcode),
		.funct       (funct),
		.rs          (rs),
		.rt          (rt),
		.dest_reg    (dest_reg),
		.reg_write   (reg_write),
		.imm_ext     (imm_ext)
	);

	//////////////////////////////
	// Registers and write-back
	//////////////////////////////

	register_bank u_register_bank
	(
		.clk         (clk),
		.reset       (reset),
		.rs_addr     (rs_addr),
		.rt_addr     (rt_addr),
		.wr_en       (wr_en),
		.wr_reg      (wr_reg),
		.wr_data     (wr_data),
		.read_data_1 (read_data_1),
		.read_data_2 (read_data_2),
		.jr_target   (jr_target)
	);

	wb_arbiter u_wb_arbiter
	(
		.clk           (clk),
		.reset         (reset),
		.alu_wb_valid  (alu_wb_valid),
		.alu_wb_reg    (alu_wb_reg),
		.alu_wb_data   (alu_wb_data),
		.load_wb_valid (load_wb_valid),
		.load_wb_reg   (load_wb_reg),
		.load_wb_data  (load_wb_data),
		.wr_en         (wr_en),
		.wr_reg        (wr_reg),
		.wr_data       (wr_data)
	);

endmodule

// ==== verif/tb_decode_stage.sv ====
`timescale 1ns/100ps

module tb_decode_stage;

	localparam int cycle_limit  = 2000; // Several times the directed test length
	localparam int dec_wait_max = 8;    // Cycles allowed for dec_valid to show

	logic                                clk = 1'b0;
	logic                                reset;
	logic                                instr_valid;
	logic [mips_pkg::data_width-1:0]     instr;
	logic                                alu_wb_valid;
	logic [mips_pkg::reg_addr_width-1:0] alu_wb_reg;
	logic [mips_pkg::data_width-1:0]     alu_wb_data;
	logic                                load_wb_valid;
	logic [mips_pkg::reg_addr_width-1:0] load_wb_reg;
	logic [mips_pkg::data_width-1:0]     load_wb_data;
	logic                                dec_valid;
	logic [mips_pkg::opcode_width-1:0]   opcode;
	logic [mips_pkg::funct_width-1:0]    funct;
	logic [mips_pkg::reg_addr_width-1:0] rs;
	logic [mips_pkg::reg_addr_width-1:0] rt;
	logic [mips_pkg::reg_addr_width-1:0] dest_reg;
	logic                                reg_write;
	logic [mips_pkg::data_width-1:0]     imm_ext;
	logic [mips_pkg::data_width-1:0]     read_data_1;
	logic [mips_pkg::data_width-1:0]     read_data_2;
	logic [mips_pkg::data_width-1:0]     jr_target;

	logic [mips_pkg::data_width-1:0] model [mips_pkg::reg_count]; // Expected bank contents
	int          error_count = 0;
	int          check_count = 0;
	int          cycle_count = 0;

	always #4 clk = ~clk; // 8 ns period

	decode_stage u_decode_stage
	(
		.clk           (clk),
		.reset         (reset),
		.instr_valid   (instr_valid),
		.instr         (instr),
		.alu_wb_valid  (alu_wb_valid),
		.alu_wb_reg    (alu_wb_reg),
		.alu_wb_data   (alu_wb_data),
		.load_wb_valid (load_wb_valid),
		.load_wb_reg   (load_wb_reg),
		.load_wb_data  (load_wb_data),
		.dec_valid     (dec_valid),
		.opcode        (opcode),
		.funct         (funct),
		.rs            (rs),
		.rt            (rt),
		.dest_reg      (dest_reg),
		.reg_write     (reg_write),
		.imm_ext       (imm_ext),
		.read_data_1   (read_data_1),
		.read_data_2   (read_data_2),
		.jr_target     (jr_target)
	);

	// Run limit
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("Run stopped after %0d cycles without finishing the tests", cycle_count);
			$display("Verification failed");
			$finish;
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic compare(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
		end
	endtask

	function automatic logic [31:0] build_rtype(input logic [4:0] f_rs, input logic [4:0] f_rt,
		input logic [4:0] f_rd, input logic [5:0] f_funct);
		return {mips_pkg::op_rtype, f_rs, f_rt, f_rd, 5'd0, f_funct}; // shamt unused
	endfunction

	function automatic logic [31:0] build_itype(input logic [5:0] op, input logic [4:0] f_rs,
		input logic [4:0] f_rt, input logic [15:0] imm);
		return {op, f_rs, f_rt, imm};
	endfunction

	// Opcodes listed as register writers
	function automatic logic writes_register(input logic [5:0] op);
		return (op == mips_pkg::op_rtype) || (op == mips_pkg::op_lw) ||
			(op == mips_pkg::op_addi) || (op == mips_pkg::op_ori);
	endfunction

	function automatic void record_write(input logic [4:0] r, input logic [31:0] d);
		if (r != 5'd0)
			model[r] = d; // r0 ignores writes
	endfunction

	task automatic idle_cycle();
		@(posedge clk);
		instr_valid   <= 1'b0;
		alu_wb_valid  <= 1'b0;
		load_wb_valid <= 1'b0;
	endtask

	// One cycle of write-back strobes, model follows arrival order
	task automatic strobe_writeback(input logic load_v, input logic [4:0] load_r,
		input logic [31:0] load_d, input logic alu_v, input logic [4:0] alu_r,
		input logic [31:0] alu_d);
		@(posedge clk);
		instr_valid   <= 1'b0;
		load_wb_valid <= load_v;
		load_wb_reg   <= load_r;
		load_wb_data  <= load_d;
		alu_wb_valid  <= alu_v;
		alu_wb_reg    <= alu_r;
		alu_wb_data   <= alu_d;
		if (load_v)
			record_write(load_r, load_d);
		if (alu_v)
			record_write(alu_r, alu_d);
	endtask

	// Strobe one instruction, wait for dec_valid, check every output
	task automatic decode_and_check(input logic [31:0] word);
		logic [5:0]  op;
		logic [4:0]  f_rs;
		logic [4:0]  f_rt;
		logic [4:0]  exp_dest;
		logic [15:0] imm;
		logic        exp_write;
		int          waited;
		op        = word[31:26];
		f_rs      = word[25:21];
		f_rt      = word[20:16];
		imm       = word[15:0];
		exp_dest  = (op == mips_pkg::op_rtype) ? word[15:11] : f_rt;
		exp_write = writes_register(op) && (exp_dest != 5'd0);
		@(posedge clk);
		instr_valid   <= 1'b1;
		instr         <= word;
		alu_wb_valid  <= 1'b0;
		load_wb_valid <= 1'b0;
		@(posedge clk);
		instr_valid <= 1'b0; // Held instr keeps jr_target steady
		waited = 0;
		while (waited == 0 || (!dec_valid && waited < dec_wait_max))
		begin
			@(negedge clk);
			waited++;
		end
		if (!dec_valid)
		begin
			error_count++;
			$display("dec_valid never rose after instruction 0x%08h", word);
		end
		else
		begin
			compare("dec_valid latency", 32'(waited), 32'd1);
			compare("opcode", 32'(opcode), 32'(op));
			compare("funct", 32'(funct), 32'(word[5:0]));
			compare("rs", 32'(rs), 32'(f_rs));
			compare("rt", 32'(rt), 32'(f_rt));
			compare("dest_reg", 32'(dest_reg), 32'(exp_dest));
			compare("reg_write", 32'(reg_write), 32'(exp_write));
			compare("imm_ext", imm_ext, {{16{imm[15]}}, imm});
			compare("read_data_1", read_data_1, model[f_rs]);
			compare("read_data_2", read_data_2, model[f_rt]);
			compare("jr_target", jr_target, model[f_rs]);
		end
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic reset_state_test();
		for (int i = 0; i < mips_pkg::reg_count; i++)
		begin
			decode_and_check(build_rtype(5'(i), 5'(i), 5'(i), 6'h20));
			compare("read_data_1 reset value", read_data_1, 32'(i)); // Register i holds i
		end
	endtask

	task automatic rtype_decode_test();
		decode_and_check(build_rtype(5'd5, 5'd9, 5'd12, 6'h22));
		@(negedge clk);
		compare("dec_valid pulse end", 32'(dec_valid), 32'd0);
		decode_and_check(build_rtype(5'd3, 5'd7, 5'd0, 6'h25)); // rd of zero, no write
	endtask

	task automatic itype_decode_test();
		logic [5:0]  ops [5];
		logic [15:0] pos_imm;
		logic [15:0] neg_imm;
		ops     = '{mips_pkg::op_addi, mips_pkg::op_lw, mips_pkg::op_sw,
			mips_pkg::op_beq, mips_pkg::op_ori};
		pos_imm = 16'($urandom) & 16'h7fff;
		neg_imm = 16'($urandom) | 16'h8000; // Sign bit forced
		for (int i = 0; i < 5; i++)
		begin
			decode_and_check(build_itype(ops[i], 5'd4, 5'(10 + i), pos_imm));
			decode_and_check(build_itype(ops[i], 5'd6, 5'(20 + i), neg_imm));
		end
		decode_and_check(build_itype(mips_pkg::op_addi, 5'd2, 5'd0, 16'h0011));
	endtask

	task automatic single_writeback_test();
		logic [4:0]  alu_reg;
		logic [4:0]  load_reg;
		alu_reg  = 5'(1 + ($urandom % 31));
		load_reg = 5'(1 + ($urandom % 31));
		strobe_writeback(1'b0, 5'd0, 32'd0, 1'b1, alu_reg, $urandom);
		decode_and_check(build_rtype(alu_reg, 5'd0, 5'd1, 6'h20));
		strobe_writeback(1'b1, load_reg, $urandom, 1'b0, 5'd0, 32'd0);
		decode_and_check(build_itype(mips_pkg::op_lw, load_reg, alu_reg, 16'h0004));
		strobe_writeback(1'b0, 5'd0, 32'd0, 1'b1, 5'd0, 32'hdead_beef); // r0 target
		decode_and_check(build_rtype(5'd0, 5'd0, 5'd2, 6'h20));
	endtask

	task automatic collision_test();
		logic [4:0]  first_reg;
		logic [4:0]  second_reg;
		logic [31:0] newer;
		first_reg  = 5'(1 + ($urandom % 15));  // 1 to 15
		second_reg = 5'(16 + ($urandom % 16)); // 16 to 31, never equal
		newer      = $urandom;
		strobe_writeback(1'b1, first_reg, $urandom, 1'b1, second_reg, $urandom);
		idle_cycle(); // Slot drains here
		decode_and_check(build_rtype(first_reg, second_reg, 5'd3, 6'h20));
		// Older ALU value parked, newer one follows to the same register
		strobe_writeback(1'b1, first_reg, $urandom, 1'b1, second_reg, $urandom);
		strobe_writeback(1'b0, 5'd0, 32'd0, 1'b1, second_reg, newer);
		idle_cycle();
		idle_cycle();
		decode_and_check(build_rtype(second_reg, first_reg, 5'd3, 6'h20));
		compare("read_data_1 latest ALU value", read_data_1, newer);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial
	begin
		void'($urandom(32'h5890_5012));
		reset         <= 1'b1;
		instr_valid   <= 1'b0;
		instr         <= '0;
		alu_wb_valid  <= 1'b0;
		alu_wb_reg    <= '0;
		alu_wb_data   <= '0;
		load_wb_valid <= 1'b0;
		load_wb_reg   <= '0;
		load_wb_data  <= '0;
		for (int i = 0; i < mips_pkg::reg_count; i++)
			model[i] = 32'(i); // Reset contents
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		reset_state_test();
		rtype_decode_test();
		itype_decode_test();
		single_writeback_test();
		collision_test();
		idle_cycle();
		$display("Checks: %0d, errors: %0d, cycles: %0d", check_count, error_count, cycle_count);
		if (error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== all.f ====
design/mips_pkg.sv
design/instr_decoder.sv
design/wb_arbiter.sv
design/register_bank.sv
design/decode_stage.sv
verif/tb_decode_stage.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_decode_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_decode_stage -f all.f

run: compile
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
